// File: sources.f
dma_pkg.sv
dma_stage_if.sv
io_translation_stage.sv
register_bank_stage.sv
read_response_stage.sv
dma_endpoint.sv
dma_endpoint_properties.sv
dma_endpoint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the DMA endpoint testbench with Verilator, runs it and checks the log

rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module dma_endpoint_tb \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vdma_endpoint_tb > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

// File: dma_endpoint_input.txt
// DMA endpoint command vectors, all fields hex, op ff ends the list
// op channel io_addr data expected (op 0 map, 1 write, 2 read, 3 ignored)
1 0 05 12345 00000
2 0 05 00000 12345
1 3 3f abcde 00000
2 3 3f 00000 abcde
1 1 05 11111 00000
1 2 05 22222 00000
2 0 05 00000 12345
2 1 05 00000 11111
2 2 05 00000 22222
1 0 14 0beef 00000
0 0 0a 00014 00000
2 0 0a 00000 0beef
1 0 0a 5a5a5 00000
2 0 14 00000 5a5a5
1 1 0a 77777 00000
2 1 14 00000 77777
2 2 00 00000 00000
1 2 00 fffff 00000
2 2 00 00000 00000
0 0 05 00000 00000
1 0 05 99999 00000
2 0 05 00000 00000
0 0 06 00005 00000
2 0 06 00000 12345
3 0 06 00000 00000
2 0 06 00000 12345
2 0 14 00000 5a5a5
2 1 14 00000 77777
2 3 3f 00000 abcde
2 2 06 00000 22222
2 1 06 00000 11111
2 0 05 00000 00000
2 1 0a 00000 77777
ff 0 00 00000 00000

// File: dma_endpoint_tb.sv
// DMA endpoint testbench
// Replays command vectors from a file and checks every read response,
// acknowledging responses after pseudo-random delays
`timescale 1ns/10ps

module dma_endpoint_tb import dma_pkg::*; ();

    localparam int MAX_VECTORS = 64;
    localparam int FIELDS = 5;

    logic                    clock;
    logic                    reset;
    logic                    cmd_req;
    cmd_op_t                 cmd_op;
    logic [CHANNEL_BITS-1:0] cmd_channel;
    logic [IO_ADDR_BITS-1:0] cmd_io_addr;
    logic [DATA_WIDTH-1:0]   cmd_data;
    logic                    cmd_ack;
    logic                    rsp_req;
    logic [DATA_WIDTH-1:0]   rsp_data;
    logic                    rsp_ack;

    logic [31:0]           vectors [FIELDS * MAX_VECTORS];
    logic [DATA_WIDTH-1:0] expected_q [$];
    logic [31:0]           lfsr;
    int vector_count;
    int read_count;
    int response_count;
    int cycle_limit;
    int cycle_count = 0;

    dma_endpoint dut0 (
        .clock       (clock),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd_op      (cmd_op),
        .cmd_channel (cmd_channel),
        .cmd_io_addr (cmd_io_addr),
        .cmd_data    (cmd_data),
        .cmd_ack     (cmd_ack),
        .rsp_req     (rsp_req),
        .rsp_data    (rsp_data),
        .rsp_ack     (rsp_ack)
    );

    always #5 clock = ~clock;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // One full four-phase command transfer, starting on a falling edge
    task automatic send_command(input logic [1:0] op, input logic [CHANNEL_BITS-1:0] channel,
                                input logic [IO_ADDR_BITS-1:0] io_addr,
                                input logic [DATA_WIDTH-1:0] data);
        cmd_op = cmd_op_t'(op);
        cmd_channel = channel;
        cmd_io_addr = io_addr;
        cmd_data = data;
        cmd_req = 1'b1;
        while (!cmd_ack) @(negedge clock);
        cmd_req = 1'b0;
        while (cmd_ack) @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        int base;
        clock = 1'b0;
        reset = 1'b0;
        cmd_req = 1'b0;
        cmd_op = OP_MAP;
        cmd_channel = '0;
        cmd_io_addr = '0;
        cmd_data = '0;
        rsp_ack = 1'b0;
        lfsr = 32'hc94;
        read_count = 0;
        response_count = 0;
        cycle_limit = 100;
        $readmemh("dma_endpoint_input.txt", vectors);
        vector_count = 0;
        while (vector_count < MAX_VECTORS && vectors[vector_count * FIELDS] != 32'hff) begin
            vector_count++;
        end
        if (vector_count == 0) begin
            $display("No command vectors were found in dma_endpoint_input.txt");
            $display("Some tests failed");
            $fatal(1, "empty stimulus");
        end
        cycle_limit = vector_count * 40 + 100;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        for (int v = 0; v < vector_count; v++) begin
            base = v * FIELDS;
            // Reads are queued before the command goes out so the response finds them
            if (vectors[base][1:0] == 2'd2) begin
                expected_q.push_back(vectors[base + 4][DATA_WIDTH-1:0]);
                read_count++;
            end
            send_command(vectors[base][1:0], vectors[base + 1][CHANNEL_BITS-1:0],
                         vectors[base + 2][IO_ADDR_BITS-1:0],
                         vectors[base + 3][DATA_WIDTH-1:0]);
        end
        wait (response_count == read_count);
        repeat (4) @(negedge clock);
        // Every read has been answered, so no further response may be pending
        check_value(32'(rsp_req), 32'd0, "rsp_req after the last read response");
        $display("All tests passed");
        $finish;
    end

    initial begin : response_process
        int delay;
        logic [DATA_WIDTH-1:0] expected;
        forever begin
            @(negedge clock);
            if (reset && rsp_req && !rsp_ack) begin
                delay = 0;
                for (int i = 0; i < 3; i++) begin
                    lfsr = lfsr_step(lfsr);
                    delay = {delay[30:0], lfsr[0]};
                end
                repeat (delay) @(negedge clock);
                if (expected_q.size() == 0) begin
                    $display("A read response arrived with no read command outstanding");
                    $display("Some tests failed");
                    $fatal(1, "unexpected response");
                end
                expected = expected_q.pop_front();
                response_count++;
                check_value(32'(rsp_data), 32'(expected), "read response data");
                rsp_ack = 1'b1;
                while (rsp_req) @(negedge clock);
                rsp_ack = 1'b0;
            end
        end
    end

endmodule

// File: dma_endpoint_properties.sv
// DMA endpoint handshake properties
// Concurrent checks on the four-phase command and response ports
`timescale 1ns/10ps

module dma_endpoint_properties import dma_pkg::*; (
    input logic                  clock,
    input logic                  reset,
    input logic                  cmd_req,
    input logic                  cmd_ack,
    input logic                  rsp_req,
    input logic [DATA_WIDTH-1:0] rsp_data,
    input logic                  rsp_ack
);

    // Nothing is acknowledged in the cycle after reset
    ack_low_after_reset: assert property (@(posedge clock) !reset |=> !cmd_ack)
        else $error("cmd_ack high right after reset");

    // The ack only answers a pending request
    ack_needs_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    rsp_req_held: assert property (@(posedge clock) disable iff (!reset)
        rsp_req && !rsp_ack |=> rsp_req)
        else $error("rsp_req dropped before rsp_ack");

    rsp_data_stable: assert property (@(posedge clock) disable iff (!reset)
        rsp_req && $past(rsp_req) |-> $stable(rsp_data))
        else $error("rsp_data changed while rsp_req was high");

endmodule

bind dma_endpoint dma_endpoint_properties handshake_checks (
    .clock    (clock),
    .reset    (reset),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .rsp_req  (rsp_req),
    .rsp_data (rsp_data),
    .rsp_ack  (rsp_ack)
);

// File: dma_endpoint.sv
// DMA endpoint top level
// Translation, register bank and response stages chained into a
// three-deep pipeline behind four-phase command and response ports
`timescale 1ns/10ps

module dma_endpoint import dma_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    cmd_req,
    input  cmd_op_t                 cmd_op,
    input  logic [CHANNEL_BITS-1:0] cmd_channel,
    input  logic [IO_ADDR_BITS-1:0] cmd_io_addr,
    input  logic [DATA_WIDTH-1:0]   cmd_data,
    output logic                    cmd_ack,
    output logic                    rsp_req,
    output logic [DATA_WIDTH-1:0]   rsp_data,
    input  logic                    rsp_ack
);

    dma_stage_if bank_link();

    logic                  read_req;
    logic [DATA_WIDTH-1:0] read_data;
    logic                  read_ack;

    io_translation_stage translation (
        .clock       (clock),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd_op      (cmd_op),
        .cmd_channel (cmd_channel),
        .cmd_io_addr (cmd_io_addr),
        .cmd_data    (cmd_data),
        .cmd_ack     (cmd_ack),
        .bank_link   (bank_link.source)
    );

    register_bank_stage bank (
        .clock     (clock),
        .reset     (reset),
        .bank_link (bank_link.sink),
        .read_req  (read_req),
        .read_data (read_data),
        .read_ack  (read_ack)
    );

    read_response_stage response (
        .clock     (clock),
        .reset     (reset),
        .read_req  (read_req),
        .read_data (read_data),
        .read_ack  (read_ack),
        .rsp_req   (rsp_req),
        .rsp_data  (rsp_data),
        .rsp_ack   (rsp_ack)
    );

endmodule

// File: read_response_stage.sv
// Read response stage
// Buffers one read result and presents it on the external response port
`timescale 1ns/10ps

module read_response_stage import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  read_req,
    input  logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_ack,
    output logic                  rsp_req,
    output logic [DATA_WIDTH-1:0] rsp_data,
    input  logic                  rsp_ack
);

    typedef enum logic [1:0] {RD_IDLE, RD_LATCHED, RD_ACK} rd_state_t;
    typedef enum logic [1:0] {RSP_IDLE, RSP_REQ, RSP_WAIT} rsp_state_t;

    rd_state_t  rd_state;
    rsp_state_t rsp_state;

    logic latch;

    // Buffer is free again only once the master has released rsp_ack
    assign latch = read_req && (rd_state == RD_IDLE) && (rsp_state == RSP_IDLE);

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_state <= RD_IDLE;
            rsp_state <= RSP_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE:    if (latch) rd_state <= RD_LATCHED;
                RD_LATCHED: rd_state <= RD_ACK;
                RD_ACK:     if (!read_req) rd_state <= RD_IDLE;
                default:    rd_state <= RD_IDLE;
            endcase
            case (rsp_state)
                RSP_IDLE: if (latch) rsp_state <= RSP_REQ;
                RSP_REQ:  if (rsp_ack) rsp_state <= RSP_WAIT;
                RSP_WAIT: if (!rsp_ack) rsp_state <= RSP_IDLE;
                default:  rsp_state <= RSP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (latch) begin
            rsp_data <= read_data;
        end
    end

    assign read_ack = (rd_state == RD_ACK);
    assign rsp_req = (rsp_state == RSP_REQ);

endmodule

// File: register_bank_stage.sv
// Register bank stage
// Stores the registers of all channels and performs the forwarded accesses,
// passing read results on to the response stage
`timescale 1ns/10ps

module register_bank_stage import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    dma_stage_if.sink             bank_link,
    output logic                  read_req,
    output logic [DATA_WIDTH-1:0] read_data,
    input  logic                  read_ack
);

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_READ,
        BANK_READ_DONE,
        BANK_ACK
    } bank_state_t;

    bank_state_t bank_state;

    logic [DATA_WIDTH-1:0] regs [CHANNEL_COUNT * REGS_PER_CHANNEL];

    logic start;

    assign start = (bank_state == BANK_IDLE) && bank_link.req;

    always_ff @(posedge clock) begin
        if (!reset) begin
            bank_state <= BANK_IDLE;
        end else begin
            case (bank_state)
                BANK_IDLE: begin
                    if (bank_link.req) begin
                        bank_state <= bank_link.is_read ? BANK_READ : BANK_ACK;
                    end
                end
                BANK_READ: begin
                    if (read_ack) begin
                        bank_state <= BANK_READ_DONE;
                    end
                end
                BANK_READ_DONE: begin
                    // Upstream is acked only after the read link is back to idle
                    if (!read_ack) begin
                        bank_state <= BANK_ACK;
                    end
                end
                BANK_ACK: begin
                    if (!bank_link.req) begin
                        bank_state <= BANK_IDLE;
                    end
                end
                default: bank_state <= BANK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start && !bank_link.is_read) begin
            regs[bank_link.reg_addr] <= bank_link.data;
        end
    end

    // Unmapped reads return zero instead of the stored word
    always_ff @(posedge clock) begin
        if (start && bank_link.is_read) begin
            read_data <= bank_link.data[0] ? '0 : regs[bank_link.reg_addr];
        end
    end

    assign read_req = (bank_state == BANK_READ);
    assign bank_link.ack = (bank_state == BANK_ACK);

endmodule

// File: io_translation_stage.sv
// IO translation stage
// Accepts commands from the external master, maintains the IO translation
// table and forwards translated register accesses to the register bank
`timescale 1ns/10ps

module io_translation_stage import dma_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    cmd_req,
    input  cmd_op_t                 cmd_op,
    input  logic [CHANNEL_BITS-1:0] cmd_channel,
    input  logic [IO_ADDR_BITS-1:0] cmd_io_addr,
    input  logic [DATA_WIDTH-1:0]   cmd_data,
    output logic                    cmd_ack,
    dma_stage_if.source             bank_link
);

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_REQ,
        LINK_RELEASE
    } link_state_t;

    link_state_t link_state;

    logic [IO_ADDR_BITS-1:0] io_table [REGS_PER_CHANNEL];

    logic [IO_ADDR_BITS-1:0] entry;
    logic                    unmapped;
    logic                    accept;
    logic                    forward;

    logic                     hold_is_read;
    logic [REG_ADDR_BITS-1:0] hold_addr;
    logic [DATA_WIDTH-1:0]    hold_data;

    assign entry = io_table[cmd_io_addr];
    assign unmapped = (entry == '0);

    // A command is taken only while the holding register is empty
    assign accept = cmd_req && !cmd_ack && (link_state == LINK_IDLE);

    // Reads always travel on, writes only through a mapped entry
    assign forward = (cmd_op == OP_READ) || ((cmd_op == OP_WRITE) && !unmapped);

    always_ff @(posedge clock) begin
        if (!reset) begin
            cmd_ack <= 1'b0;
        end else if (accept) begin
            cmd_ack <= 1'b1;
        end else if (!cmd_req) begin
            cmd_ack <= 1'b0;
        end
    end

    // The table comes out of reset transparent, entry i holding i
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < REGS_PER_CHANNEL; i++) begin
                io_table[i] <= IO_ADDR_BITS'(i);
            end
        end else if (accept && (cmd_op == OP_MAP)) begin
            io_table[cmd_io_addr] <= cmd_data[IO_ADDR_BITS-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            link_state <= LINK_IDLE;
        end else begin
            case (link_state)
                LINK_IDLE: begin
                    if (accept && forward) begin
                        link_state <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (bank_link.ack) begin
                        link_state <= LINK_RELEASE;
                    end
                end
                LINK_RELEASE: begin
                    // Holding register frees up once the bank drops ack
                    if (!bank_link.ack) begin
                        link_state <= LINK_IDLE;
                    end
                end
                default: link_state <= LINK_IDLE;
            endcase
        end
    end

    // Physical address is channel * 64 + entry, i.e. a plain concatenation
    always_ff @(posedge clock) begin
        if (accept && forward) begin
            hold_is_read <= (cmd_op == OP_READ);
            hold_addr <= {cmd_channel, entry};
            hold_data <= (cmd_op == OP_READ) ? DATA_WIDTH'(unmapped) : cmd_data;
        end
    end

    assign bank_link.req = (link_state == LINK_REQ);
    assign bank_link.is_read = hold_is_read;
    assign bank_link.reg_addr = hold_addr;
    assign bank_link.data = hold_data;

endmodule

// File: dma_stage_if.sv
// Pipeline link between DMA stages
// Carries one register access with a four-phase req/ack handshake
`timescale 1ns/10ps

interface dma_stage_if import dma_pkg::*; ();

    logic                     req;
    logic                     ack;
    logic                     is_read;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    // On reads, bit 0 set marks an unmapped access
    logic [DATA_WIDTH-1:0]    data;

    modport source (
        output req,
        output is_read,
        output reg_addr,
        output data,
        input  ack
    );

    modport sink (
        input  req,
        input  is_read,
        input  reg_addr,
        input  data,
        output ack
    );

endinterface

// File: dma_pkg.sv
// DMA endpoint shared definitions
// Sizes of the register file and translation table, and the command opcodes
package dma_pkg;

    // Width of one register word
    localparam int DATA_WIDTH = 20;

    // Channels of the control core, each with its own register window
    localparam int CHANNEL_COUNT = 4;
    localparam int CHANNEL_BITS = 2;
    localparam int REGS_PER_CHANNEL = 64;

    // Logical IO address, also the index and entry width of the translation table
    localparam int IO_ADDR_BITS = 6;

    // Physical register address, channel on top of the translated index
    localparam int REG_ADDR_BITS = CHANNEL_BITS + IO_ADDR_BITS;

    // Command opcodes on the external command port
    // Code 3 is acknowledged and otherwise ignored
    typedef enum logic [1:0] {
        OP_MAP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } cmd_op_t;

endpackage
